//--- logic/pcs_config.svh
`ifndef PCS_CONFIG_SVH
`define PCS_CONFIG_SVH

`define PCS_DATA_W		32
`define PCS_ADDR_W		3

`define PCS_ADDR_SCRATCH	3'd1
`define PCS_ADDR_WAKE_EN	3'd2
`define PCS_ADDR_CTL		3'd3
`define PCS_ADDR_STATUS		3'd4

`define PCS_WAKE_N		31	// lines numbered 1..31
`define PCS_WFI_WAKE_LSB	27	// lines 27..31 end a wfi
`define PCS_WAKE_EN_RESET	32'hffff_ffff

`define PCS_CLKON_CORE		0
`define PCS_CLKON_LM		12
`define PCS_CLKON_DC		13

`endif

//--- logic/pcs_pkg.sv
`default_nettype none

`include "pcs_config.svh"

package pcs_pkg;

	typedef logic [`PCS_DATA_W-1:0] reg_data_t;
	typedef logic [`PCS_ADDR_W-1:0] reg_addr_t;
	typedef logic [`PCS_WAKE_N:1]   wake_vec_t;	// bit 0 does not exist
	typedef logic [4:0]             wake_idx_t;
	typedef logic [7:0]             ctl_t;		// [7:3] argument, [2:0] command
	typedef logic [7:0]             status_t;

	typedef enum logic [1:0] {
		MODE_ACTIVE_RUN  = 2'd0,
		MODE_RESET       = 2'd1,
		MODE_ACTIVE_WFI  = 2'd2,
		MODE_LIGHT_SLEEP = 2'd3
	} mode_t;

	typedef struct packed {
		logic      sel;
		logic      write;
		reg_addr_t addr;
		reg_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      any_raw;	// any synchronized line, mask ignored
		logic      any_masked;
		logic      wfi_hit;
		wake_idx_t first_idx;
	} wake_sum_t;

	typedef struct packed {
		logic core;
		logic lm;
		logic dc;
	} gate_t;	// set means gated

endpackage

`default_nettype wire

//--- logic/pcs_sync.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_sync #(
	parameter int WIDTH = 1
) (
	input  logic             pclk,
	input  logic             presetn,
	input  logic [WIDTH-1:0] async_in,
	output logic [WIDTH-1:0] sync_out
);

	logic [WIDTH-1:0] meta_q;

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			meta_q   <= '0;
			sync_out <= '0;
		end else begin
			meta_q   <= async_in;	// first stage may go metastable
			sync_out <= meta_q;
		end
	end

endmodule

`default_nettype wire

//--- logic/pcs_wakeup.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_wakeup import pcs_pkg::*; (
	input  logic      pclk,
	input  logic      presetn,
	input  wake_vec_t wakeup_event,
	input  wake_vec_t wake_en,
	output wake_sum_t wake_sum,
	output logic      raw_any
);

	wake_vec_t ev_sync;
	wake_vec_t ev_masked;

	pcs_sync #(
		.WIDTH    (`PCS_WAKE_N)
	) u_ev_sync (
		.pclk     (pclk),
		.presetn  (presetn),
		.async_in (wakeup_event),
		.sync_out (ev_sync)
	);

	assign ev_masked = ev_sync & wake_en;

	// unsynchronized, keeps clocks requested while an event is still on its way in
	assign raw_any = |(wakeup_event & wake_en);

	//////////////////////////////
	// summary for the sequencer
	//////////////////////////////

	always_comb begin
		wake_sum.any_raw    = |ev_sync;
		wake_sum.any_masked = |ev_masked;
		wake_sum.wfi_hit    = |ev_sync[`PCS_WAKE_N:`PCS_WFI_WAKE_LSB];	// mask not applied
		wake_sum.first_idx  = '0;
		for (int i = `PCS_WAKE_N; i >= 1; i--) begin	// lowest index wins
			if (ev_masked[i]) begin
				wake_sum.first_idx = wake_idx_t'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/pcs_clk_handshake.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_clk_handshake import pcs_pkg::*; (
	input  logic      pclk,
	input  logic      presetn,
	input  mode_t     mode,
	input  mode_t     target,
	input  logic      standby_ok_s,
	input  logic      wfi_hit,
	input  logic      raw_any,
	input  logic      frq_scale_ack,
	output logic      frq_scale_req,
	output reg_data_t frq_clkon,
	output gate_t     gated
);

	logic  ack_s;
	logic  sleep_off;
	gate_t off_nx;	// domains to gate on the next exchange
	gate_t off_q;

	pcs_sync #(
		.WIDTH    (1)
	) u_ack_sync (
		.pclk     (pclk),
		.presetn  (presetn),
		.async_in (frq_scale_ack),
		.sync_out (ack_s)
	);

	assign sleep_off = (mode == MODE_LIGHT_SLEEP) && (target != MODE_ACTIVE_RUN);

	always_comb begin
		off_nx.core = sleep_off || ((mode == MODE_ACTIVE_WFI) && !wfi_hit && standby_ok_s);
		off_nx.lm   = sleep_off;
		off_nx.dc   = sleep_off;
	end

	//////////////////////////////
	// four-phase exchange
	//////////////////////////////

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			frq_scale_req <= 1'b0;
			off_q         <= '1;
			gated         <= '1;
		end else begin
			frq_scale_req <= !ack_s;	// rise on low ack, fall on high ack
			if (!frq_scale_req && !ack_s) begin
				off_q <= off_nx;	// choices only move in the idle phase
			end
			if (ack_s) begin
				gated <= off_q;
			end
		end
	end

	always_comb begin
		frq_clkon                  = '0;
		frq_clkon[`PCS_CLKON_CORE] = !off_nx.core || raw_any;
		frq_clkon[`PCS_CLKON_LM]   = !off_nx.lm || raw_any;
		frq_clkon[`PCS_CLKON_DC]   = !off_nx.dc || raw_any;
	end

endmodule

`default_nettype wire

//--- logic/pcs_mode_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_mode_seq import pcs_pkg::*; (
	input  logic      pclk,
	input  logic      presetn,
	input  bus_req_t  bus,
	input  wake_sum_t wake_sum,
	input  gate_t     gated,
	input  logic      standby_ok,
	output mode_t     mode,
	output mode_t     target,
	output logic      standby_ok_s,
	output ctl_t      ctl,
	output reg_data_t status,
	output logic      wakeup,
	output logic      resetn
);

	logic       ctl_ok;
	logic       ctl_we;
	mode_t      mode_nx;
	logic [4:0] rst_cnt;
	logic       cnt_match;
	logic       core_rst;
	logic       all_on;
	logic       wait_st;
	logic       busy;
	wake_idx_t  wake_vec;
	status_t    code;

	pcs_sync #(
		.WIDTH    (1)
	) u_stby_sync (
		.pclk     (pclk),
		.presetn  (presetn),
		.async_in (standby_ok),
		.sync_out (standby_ok_s)
	);

	//////////////////////////////
	// control register
	//////////////////////////////

	always_comb begin
		casez (bus.wdata[7:0])
			8'b00001_000: ctl_ok = (mode == MODE_ACTIVE_WFI) || (mode == MODE_LIGHT_SLEEP);
			8'b?????_001,
			8'b00000_011: ctl_ok = (mode == MODE_ACTIVE_RUN);
			default:      ctl_ok = 1'b0;	// deep sleep lands here too
		endcase
	end

	assign ctl_we = bus.sel && bus.write && (bus.addr == `PCS_ADDR_CTL) && ctl_ok;

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			ctl <= '0;
		end else if (ctl_we) begin
			ctl <= bus.wdata[7:0];
		end else if ((wake_sum.any_masked && (mode == MODE_LIGHT_SLEEP)) ||
			     (wake_sum.wfi_hit && (mode == MODE_ACTIVE_WFI)) || cnt_match) begin
			ctl <= '0;
		end
	end

	always_comb begin
		casez (ctl)
			8'b?????_001: target = MODE_RESET;
			8'b00000_011: target = MODE_LIGHT_SLEEP;
			default:      target = MODE_ACTIVE_RUN;
		endcase
	end

	assign wakeup = (ctl == 8'b00001_000);

	//////////////////////////////
	// mode FSM
	//////////////////////////////

	assign all_on = (gated == 3'b000);

	always_comb begin
		mode_nx = mode;
		case (mode)
			MODE_ACTIVE_RUN: begin
				if (standby_ok_s) begin	// core has parked
					if (target == MODE_RESET) begin
						mode_nx = MODE_RESET;
					end else if ((target == MODE_LIGHT_SLEEP) && !wake_sum.any_masked) begin
						mode_nx = MODE_LIGHT_SLEEP;
					end else if (!wake_sum.wfi_hit) begin
						mode_nx = MODE_ACTIVE_WFI;
					end
				end
			end
			MODE_RESET: begin
				if ((target == MODE_ACTIVE_RUN) && !standby_ok_s) begin
					mode_nx = MODE_ACTIVE_RUN;
				end
			end
			MODE_ACTIVE_WFI: begin
				if (wake_sum.wfi_hit || !standby_ok_s) begin
					mode_nx = MODE_ACTIVE_RUN;
				end
			end
			MODE_LIGHT_SLEEP: begin
				if ((target == MODE_ACTIVE_RUN) && (wake_sum.any_masked || all_on)) begin
					mode_nx = MODE_ACTIVE_RUN;
				end
			end
			default: mode_nx = MODE_ACTIVE_RUN;
		endcase
	end

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			mode     <= MODE_ACTIVE_RUN;
			rst_cnt  <= '0;
			core_rst <= 1'b1;
			wake_vec <= '0;
		end else begin
			mode    <= mode_nx;
			rst_cnt <= ((mode == MODE_RESET) && !cnt_match) ? rst_cnt + 5'd1 : 5'd0;
			if (mode == MODE_RESET) begin
				core_rst <= 1'b1;
			end else if ((mode == MODE_ACTIVE_RUN) && all_on) begin
				core_rst <= 1'b0;	// release once every clock is back
			end
			if (mode == MODE_LIGHT_SLEEP) begin
				wake_vec <= wake_sum.first_idx;
			end
		end
	end

	assign cnt_match = (rst_cnt == ctl[7:3]) && (mode == MODE_RESET);
	assign resetn    = !core_rst && (mode != MODE_RESET);

	//////////////////////////////
	// status
	//////////////////////////////

	assign wait_st = (mode == MODE_ACTIVE_RUN) &&
			 ((target == MODE_RESET) || (target == MODE_LIGHT_SLEEP));
	assign busy    = ((mode == MODE_RESET) && !cnt_match) ||
			 ((mode == MODE_LIGHT_SLEEP) && (gated != 3'b111));

	always_comb begin
		if (wait_st) begin
			code = (target == MODE_RESET) ? 8'b00000_011 : 8'b00010_011;
		end else begin
			case (mode)
				MODE_RESET:       code = busy ? 8'b10000_011 : 8'b00100_001;
				MODE_LIGHT_SLEEP: code = busy ? 8'b10010_011 : 8'b00000_010;
				default:          code = {wake_vec, 3'b000};	// run and wfi
			endcase
		end
		status     = '0;
		status[7:0] = code;
		status[30] = wake_sum.any_masked;
		status[31] = wake_sum.any_raw;
	end

endmodule

`default_nettype wire

//--- logic/pcs_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_regs import pcs_pkg::*; (
	input  logic      pclk,
	input  logic      presetn,
	input  bus_req_t  bus,
	input  ctl_t      ctl,
	input  reg_data_t status,
	output wake_vec_t wake_en,
	output reg_data_t rdata
);

	logic      wr;
	reg_data_t scratch_q;
	reg_data_t wake_en_q;

	assign wr = bus.sel && bus.write;

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			scratch_q <= '0;
		end else if (wr && (bus.addr == `PCS_ADDR_SCRATCH)) begin
			scratch_q <= bus.wdata;
		end
	end

	always_ff @(posedge pclk or negedge presetn) begin
		if (!presetn) begin
			wake_en_q <= `PCS_WAKE_EN_RESET;	// every line may wake by default
		end else if (wr && (bus.addr == `PCS_ADDR_WAKE_EN)) begin
			wake_en_q <= bus.wdata;
		end
	end

	assign wake_en = wake_en_q[`PCS_WAKE_N:1];	// bit 0 stored, no line behind it

	always_comb begin
		rdata = '0;
		if (bus.sel) begin
			case (bus.addr)
				`PCS_ADDR_SCRATCH: rdata = scratch_q;
				`PCS_ADDR_WAKE_EN: rdata = wake_en_q;
				`PCS_ADDR_CTL:     rdata = {24'b0, ctl};
				`PCS_ADDR_STATUS:  rdata = status;
				default:           rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/pcs_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_top import pcs_pkg::*; (
	input  logic      pclk,
	input  logic      presetn,
	input  bus_req_t  bus,
	input  wake_vec_t wakeup_event,
	input  logic      standby_ok,
	input  logic      frq_scale_ack,
	output reg_data_t rdata,
	output logic      wakeup,
	output logic      frq_scale_req,
	output reg_data_t frq_clkon,
	output logic      resetn
);

	wake_vec_t wake_en;
	wake_sum_t wake_sum;
	logic      raw_any;
	mode_t     mode;
	mode_t     target;
	logic      standby_ok_s;
	ctl_t      ctl;
	reg_data_t status;
	gate_t     gated;

	pcs_regs u_regs (
		.pclk    (pclk),
		.presetn (presetn),
		.bus     (bus),
		.ctl     (ctl),
		.status  (status),
		.wake_en (wake_en),
		.rdata   (rdata)
	);

	pcs_wakeup u_wakeup (
		.pclk         (pclk),
		.presetn      (presetn),
		.wakeup_event (wakeup_event),
		.wake_en      (wake_en),
		.wake_sum     (wake_sum),
		.raw_any      (raw_any)
	);

	pcs_clk_handshake u_clk_hs (
		.pclk          (pclk),
		.presetn       (presetn),
		.mode          (mode),
		.target        (target),
		.standby_ok_s  (standby_ok_s),
		.wfi_hit       (wake_sum.wfi_hit),
		.raw_any       (raw_any),
		.frq_scale_ack (frq_scale_ack),
		.frq_scale_req (frq_scale_req),
		.frq_clkon     (frq_clkon),
		.gated         (gated)
	);

	pcs_mode_seq u_mode_seq (
		.pclk         (pclk),
		.presetn      (presetn),
		.bus          (bus),
		.wake_sum     (wake_sum),
		.gated        (gated),
		.standby_ok   (standby_ok),
		.mode         (mode),
		.target       (target),
		.standby_ok_s (standby_ok_s),
		.ctl          (ctl),
		.status       (status),
		.wakeup       (wakeup),
		.resetn       (resetn)
	);

endmodule

`default_nettype wire

//--- testbench/pcs_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_asserts import pcs_pkg::*; (
	input wire logic  pclk,
	input wire logic  presetn,
	input wire logic  frq_scale_req,
	input wire logic  ack_s,
	input wire mode_t mode,
	input wire logic  resetn
);

	//////////////////////////////
	// handshake
	//////////////////////////////

	req_rise_on_low_ack: assert property (@(posedge pclk) disable iff (!presetn)
		$rose(frq_scale_req) |-> !$past(ack_s))
		else $error("frq_scale_req rose while the synchronized ack was high");

	//////////////////////////////
	// mode and core reset
	//////////////////////////////

	reset_mode_holds_resetn: assert property (@(posedge pclk) disable iff (!presetn)
		(mode == MODE_RESET) |-> !resetn)
		else $error("resetn high while in reset mode");

	no_wfi_after_sleep: assert property (@(posedge pclk) disable iff (!presetn)
		(mode == MODE_LIGHT_SLEEP) |=> (mode != MODE_ACTIVE_WFI))
		else $error("mode went from light sleep straight to wfi");

endmodule

`default_nettype wire

//--- testbench/pcs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_config.svh"

module pcs_tb import pcs_pkg::*; ();

	localparam int POLL_LIMIT = 150;	// cycles per row
	localparam int RAND_LINE  = 63;	// line code for the random wake line

	typedef struct packed {
		logic      wr_ctl;
		ctl_t      ctl;
		reg_data_t wake_en;
		logic [5:0] line;
		logic      stby;
		reg_data_t status;	// expected status word
		logic      add_k;	// expected code carries the random index
		logic      rstn;
		logic [2:0] clkon;	// dc, lm, core
		ctl_t      ctl_exp;
		status_t   mid;		// busy code expected on the way or zero
		logic      wakeup;
	} row_t;

	logic      pclk;
	logic      presetn;
	bus_req_t  bus;
	wake_vec_t wakeup_event;
	logic      standby_ok;
	logic      frq_scale_ack;
	reg_data_t rdata;
	logic      wakeup;
	logic      frq_scale_req;
	reg_data_t frq_clkon;
	logic      resetn;
	logic      req_d;

	row_t   rows[$];
	string  names[$];
	integer seed = 32'hf318;
	int     k;
	int     errors = 0;
	int     failed_tests = 0;
	int     tests = 0;

	pcs_top pcs_top_i (
		.pclk          (pclk),
		.presetn       (presetn),
		.bus           (bus),
		.wakeup_event  (wakeup_event),
		.standby_ok    (standby_ok),
		.frq_scale_ack (frq_scale_ack),
		.rdata         (rdata),
		.wakeup        (wakeup),
		.frq_scale_req (frq_scale_req),
		.frq_clkon     (frq_clkon),
		.resetn        (resetn)
	);

	bind pcs_top pcs_asserts u_asserts (
		.pclk          (pclk),
		.presetn       (presetn),
		.frq_scale_req (frq_scale_req),
		.ack_s         (u_clk_hs.ack_s),
		.mode          (mode),
		.resetn        (resetn)
	);

	always #20 pclk = ~pclk;

	// clock controller model that echoes req on ack one cycle later
	always @(posedge pclk) begin
		#2;
		frq_scale_ack = req_d;
		req_d         = frq_scale_req;
	end

	task automatic add_row(input string nm, input logic wr, input ctl_t c, input reg_data_t en,
			input int ln, input logic sb, input reg_data_t st, input logic ak,
			input logic rn, input logic [2:0] ck, input ctl_t ce, input status_t md,
			input logic wk);
		row_t r;
		r = '{wr_ctl: wr, ctl: c, wake_en: en, line: 6'(ln), stby: sb, status: st,
		      add_k: ak, rstn: rn, clkon: ck, ctl_exp: ce, mid: md, wakeup: wk};
		rows.push_back(r);
		names.push_back(nm);
	endtask

	task automatic bus_write(input reg_addr_t a, input reg_data_t d);
		@(posedge pclk);
		#2;
		bus = '{sel: 1'b1, write: 1'b1, addr: a, wdata: d};
		@(posedge pclk);
		#2;
		bus = '0;
	endtask

	task automatic bus_read(input reg_addr_t a, output reg_data_t d);
		@(posedge pclk);
		#2;
		bus = '{sel: 1'b1, write: 1'b0, addr: a, wdata: '0};
		@(negedge pclk);
		d = rdata;
	endtask

	task automatic check_value(input string nm, input reg_data_t exp, input reg_data_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", nm, exp, act);
			errors++;
		end
	endtask

	function automatic logic [2:0] clkon_bits();
		return {frq_clkon[`PCS_CLKON_DC], frq_clkon[`PCS_CLKON_LM],
			frq_clkon[`PCS_CLKON_CORE]};
	endfunction

	task automatic apply_row(input int r);
		row_t      rw;
		reg_data_t exp_st;
		reg_data_t got_st;
		reg_data_t got_ctl;
		logic      got_rn;
		logic [2:0] got_ck;
		wake_vec_t ev;
		bit        done;
		bit        mid_seen;
		int        waited;
		int        err_before;
		rw = rows[r];
		err_before = errors;
		exp_st = rw.status | (rw.add_k ? reg_data_t'(k << 3) : '0);
		ev = '0;
		if (rw.line == RAND_LINE) begin
			ev[k] = 1'b1;
		end else if (rw.line != 0) begin
			ev[rw.line] = 1'b1;
		end
		bus_write(`PCS_ADDR_WAKE_EN, rw.wake_en);
		if (rw.wr_ctl) begin
			bus_write(`PCS_ADDR_CTL, {24'b0, rw.ctl});	// before standby moves
		end
		@(posedge pclk);
		#2;
		standby_ok   = rw.stby;
		wakeup_event = ev;
		bus = '{sel: 1'b1, write: 1'b0, addr: `PCS_ADDR_STATUS, wdata: '0};
		done = 0;
		mid_seen = (rw.mid == 0);
		waited = 0;
		while (!done && waited < POLL_LIMIT) begin
			@(negedge pclk);
			got_st = rdata;
			got_rn = resetn;
			got_ck = clkon_bits();
			if (got_st[7:0] == rw.mid) begin
				mid_seen = 1;
			end
			if (got_st == exp_st && got_rn == rw.rstn && got_ck == rw.clkon) begin
				done = 1;
			end
			waited++;
		end
		if (!done) begin
			check_value({names[r], " status"}, exp_st, got_st);
			check_value({names[r], " resetn"}, reg_data_t'(rw.rstn), reg_data_t'(got_rn));
			check_value({names[r], " clkon"}, reg_data_t'(rw.clkon), reg_data_t'(got_ck));
			$display("%s: no stable result within %0d cycles", names[r], POLL_LIMIT);
			errors++;
		end
		if (!mid_seen) begin
			$display("%s: busy code %h never showed on the way", names[r], rw.mid);
			errors++;
		end
		bus_read(`PCS_ADDR_CTL, got_ctl);
		check_value({names[r], " ctl"}, {24'b0, rw.ctl_exp}, got_ctl);
		check_value({names[r], " wakeup"}, reg_data_t'(rw.wakeup), reg_data_t'(wakeup));
		tests++;
		if (errors == err_before) begin
			$display("%s: ok", names[r]);
		end else begin
			$display("%s: FAILED", names[r]);
			failed_tests++;
		end
	endtask

	task automatic reg_tests();
		reg_data_t d;
		int        err_before;
		err_before = errors;
		bus_read(`PCS_ADDR_WAKE_EN, d);
		check_value("wake_en reset", 32'hffff_ffff, d);
		bus_write(`PCS_ADDR_SCRATCH, 32'h5a5a_c3c3);
		bus_read(`PCS_ADDR_SCRATCH, d);
		check_value("scratch", 32'h5a5a_c3c3, d);
		bus_write(`PCS_ADDR_WAKE_EN, 32'h1234_5678);
		bus_read(`PCS_ADDR_WAKE_EN, d);
		check_value("wake_en", 32'h1234_5678, d);
		bus_read(3'd0, d);
		check_value("addr 0", '0, d);
		bus_read(3'd5, d);
		check_value("addr 5", '0, d);
		bus_read(3'd7, d);
		check_value("addr 7", '0, d);
		tests++;
		if (errors == err_before) begin
			$display("register readback: ok");
		end else begin
			$display("register readback: FAILED");
			failed_tests++;
		end
	endtask

	initial begin
		//      name                wr  ctl    wake_en        ln sb
		//          status         k  rn clkon   ctl    mid    wakeup
		add_row("reset_wait",       1, 8'h29, 32'hffff_ffff, 0, 0,
			32'h0000_0003, 0, 1, 3'b111, 8'h29, 8'h00, 0);
		add_row("reset_count",      0, 8'h00, 32'hffff_ffff, 0, 1,
			32'h0000_0021, 0, 0, 3'b111, 8'h00, 8'h83, 0);
		add_row("reset_exit",       0, 8'h00, 32'hffff_ffff, 0, 0,
			32'h0000_0000, 0, 1, 3'b111, 8'h00, 8'h00, 0);
		add_row("sleep_enter",      1, 8'h03, 32'hffff_ffff, 0, 1,
			32'h0000_0002, 0, 1, 3'b000, 8'h03, 8'h93, 0);
		add_row("sleep_wake",       0, 8'h00, 32'hffff_ffff, RAND_LINE, 0,
			32'hc000_0000, 1, 1, 3'b111, 8'h00, 8'h00, 0);
		add_row("wake_release",     0, 8'h00, 32'hffff_ffff, 0, 0,
			32'h0000_0000, 1, 1, 3'b111, 8'h00, 8'h00, 0);
		add_row("wfi_enter",        0, 8'h00, 32'hffff_ffff, 0, 1,
			32'h0000_0000, 1, 1, 3'b110, 8'h00, 8'h00, 0);
		add_row("wfi_wake_28",      0, 8'h00, 32'hffff_ffff, 28, 1,
			32'hc000_0000, 1, 1, 3'b111, 8'h00, 8'h00, 0);
		add_row("wfi_release",      0, 8'h00, 32'hffff_ffff, 0, 0,
			32'h0000_0000, 1, 1, 3'b111, 8'h00, 8'h00, 0);
		add_row("sleep_again",      1, 8'h03, 32'hffff_ffdf, 0, 1,
			32'h0000_0002, 0, 1, 3'b000, 8'h03, 8'h93, 0);
		add_row("disabled_wake",    0, 8'h00, 32'hffff_ffdf, 5, 1,
			32'h8000_0002, 0, 1, 3'b000, 8'h03, 8'h00, 0);
		add_row("reset_in_sleep",   1, 8'h29, 32'hffff_ffdf, 5, 1,
			32'h8000_0002, 0, 1, 3'b000, 8'h03, 8'h00, 0);
		add_row("wake_cmd",         1, 8'h08, 32'hffff_ffdf, 0, 0,
			32'h0000_0000, 0, 1, 3'b111, 8'h08, 8'h00, 1);
		add_row("deep_sleep_cmd",   1, 8'h04, 32'hffff_ffff, 0, 0,
			32'h0000_0000, 0, 1, 3'b111, 8'h08, 8'h00, 1);
		add_row("sleep_arg_in_run", 1, 8'h0b, 32'hffff_ffff, 0, 0,
			32'h0000_0000, 0, 1, 3'b111, 8'h08, 8'h00, 1);
	end

	initial begin
		int waited;
		pclk          = 1'b0;
		presetn       = 1'b0;
		bus           = '0;
		wakeup_event  = '0;
		standby_ok    = 1'b0;
		frq_scale_ack = 1'b0;
		req_d         = 1'b0;
		k = ($unsigned($random(seed)) % 31) + 1;
		repeat (2) @(posedge pclk);
		#2;
		if (frq_scale_req !== 1'b0 || wakeup !== 1'b0 || resetn !== 1'b0) begin
			$display("outputs not at their reset levels during reset");
			errors++;
		end
		presetn = 1'b1;
		waited = 0;
		while (!resetn && waited < POLL_LIMIT) begin	// first handshake ungates the clocks
			@(negedge pclk);
			waited++;
		end
		if (!resetn) begin
			$display("resetn never rose after reset");
			errors++;
		end
		reg_tests();
		for (int r = 0; r < rows.size(); r++) begin
			apply_row(r);
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			 tests, tests - failed_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#1;
		repeat (rows.size() * 200) @(posedge pclk);
		$display("watchdog expired after %0d cycles, run stopped", rows.size() * 200);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/pcs_pkg.sv
logic/pcs_sync.sv
logic/pcs_wakeup.sv
logic/pcs_clk_handshake.sv
logic/pcs_mode_seq.sv
logic/pcs_regs.sv
logic/pcs_top.sv
testbench/pcs_asserts.sv
testbench/pcs_tb.sv

//--- run.sh
#!/bin/sh
# build and run the pcs testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module pcs_tb -o pcs_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/pcs_sim)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
